// ==== src/mipsPkg.sv ====
package mipsPkg;

    typedef logic [31:0] word_t;                  // Data word
    typedef logic [4:0]  regAddr_t;               // Register number
    typedef logic [4:0]  shamt_t;                 // Shift amount
    typedef logic [5:0]  aluCtrl_t;               // ALU control code

    // ALU control codes
    localparam aluCtrl_t ALU_ADD  = 6'd0;         // Wraps without overflow trap
    localparam aluCtrl_t ALU_ADDU = 6'd1;
    localparam aluCtrl_t ALU_SUB  = 6'd2;         // Wraps like SUBU
    localparam aluCtrl_t ALU_BEQ  = 6'd9;         // Compare only
    localparam aluCtrl_t ALU_BNE  = 6'd10;        // Compare only
    localparam aluCtrl_t ALU_JUMP = 6'd14;        // No-op result
    localparam aluCtrl_t ALU_SRAV = 6'd15;
    localparam aluCtrl_t ALU_LUI  = 6'd17;
    localparam aluCtrl_t ALU_AND  = 6'd18;
    localparam aluCtrl_t ALU_OR   = 6'd19;
    localparam aluCtrl_t ALU_NOR  = 6'd20;
    localparam aluCtrl_t ALU_XOR  = 6'd21;
    localparam aluCtrl_t ALU_SLL  = 6'd23;
    localparam aluCtrl_t ALU_SRL  = 6'd24;
    localparam aluCtrl_t ALU_SRA  = 6'd28;
    localparam aluCtrl_t ALU_SLT  = 6'd30;
    localparam aluCtrl_t ALU_SLTU = 6'd31;
    localparam aluCtrl_t ALU_SLLV = 6'd36;
    localparam aluCtrl_t ALU_SRLV = 6'd37;
    localparam aluCtrl_t ALU_SUBU = 6'd45;

    // Primary opcode field in instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;    // R-type with funct deciding
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;    // Link write not supported
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // Funct field of SPECIAL in instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // Second ALU operand source
    typedef enum logic [1:0] {
        srcReg,                                   // Forwarded rt value
        srcImmSigned,                             // Sign-extended imm16
        srcImmZero,                               // Zero-extended imm16
        srcShamt                                  // rt value shifted by shamt field
    } operandSrc_t;

endpackage

// ==== src/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
    input  mipsPkg::word_t      instr,            // Instruction word
    output mipsPkg::aluCtrl_t   aluCtrl,          // ALU operation
    output mipsPkg::operandSrc_t srcSel,          // Operand B source
    output logic [15:0]         imm16,            // Raw immediate field
    output mipsPkg::shamt_t     shamt,            // Shift amount field
    output mipsPkg::regAddr_t   rsAddr,
    output mipsPkg::regAddr_t   rtAddr,
    output mipsPkg::regAddr_t   destAddr,         // rd for R-type, rt for immediates
    output logic                writeReq          // Result goes to a register
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mipsPkg::regAddr_t   rdAddr;
    logic                writeInstr;              // Instruction class writes a register

    assign opcode = instr[31:26];
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        aluCtrl    = mipsPkg::ALU_JUMP;           // Unknown opcodes act as no-ops
        srcSel     = mipsPkg::srcImmSigned;       // Most I-type sign-extend
        destAddr   = rtAddr;
        writeInstr = 1'b1;
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                srcSel   = mipsPkg::srcReg;
                destAddr = rdAddr;
                case (funct)
                    mipsPkg::FN_SLL: begin
                        aluCtrl = mipsPkg::ALU_SLL;
                        srcSel  = mipsPkg::srcShamt;
                    end
                    mipsPkg::FN_SRL: begin
                        aluCtrl = mipsPkg::ALU_SRL;
                        srcSel  = mipsPkg::srcShamt;
                    end
                    mipsPkg::FN_SRA: begin
                        aluCtrl = mipsPkg::ALU_SRA;
                        srcSel  = mipsPkg::srcShamt;
                    end
                    mipsPkg::FN_SLLV: aluCtrl = mipsPkg::ALU_SLLV;
                    mipsPkg::FN_SRLV: aluCtrl = mipsPkg::ALU_SRLV;
                    mipsPkg::FN_SRAV: aluCtrl = mipsPkg::ALU_SRAV;
                    mipsPkg::FN_ADD:  aluCtrl = mipsPkg::ALU_ADD;
                    mipsPkg::FN_ADDU: aluCtrl = mipsPkg::ALU_ADDU;
                    mipsPkg::FN_SUB:  aluCtrl = mipsPkg::ALU_SUB;
                    mipsPkg::FN_SUBU: aluCtrl = mipsPkg::ALU_SUBU;
                    mipsPkg::FN_AND:  aluCtrl = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   aluCtrl = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  aluCtrl = mipsPkg::ALU_XOR;
                    mipsPkg::FN_NOR:  aluCtrl = mipsPkg::ALU_NOR;
                    mipsPkg::FN_SLT:  aluCtrl = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU: aluCtrl = mipsPkg::ALU_SLTU;
                    default:          writeInstr = 1'b0;  // JR and unknown funct
                endcase
            end
            mipsPkg::OP_ADDI:  aluCtrl = mipsPkg::ALU_ADD;
            mipsPkg::OP_ADDIU: aluCtrl = mipsPkg::ALU_ADDU;
            mipsPkg::OP_SLTI:  aluCtrl = mipsPkg::ALU_SLT;
            mipsPkg::OP_SLTIU: aluCtrl = mipsPkg::ALU_SLTU;  // Sign-extended, unsigned compare
            mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI: begin
                srcSel = mipsPkg::srcImmZero;
                case (opcode)
                    mipsPkg::OP_ANDI: aluCtrl = mipsPkg::ALU_AND;
                    mipsPkg::OP_ORI:  aluCtrl = mipsPkg::ALU_OR;
                    mipsPkg::OP_XORI: aluCtrl = mipsPkg::ALU_XOR;
                    default:          aluCtrl = mipsPkg::ALU_LUI;
                endcase
            end
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                aluCtrl    = (opcode == mipsPkg::OP_BEQ) ? mipsPkg::ALU_BEQ : mipsPkg::ALU_BNE;
                srcSel     = mipsPkg::srcReg;     // Compare rs with rt
                writeInstr = 1'b0;
            end
            default: writeInstr = 1'b0;           // J, JAL and unknown opcodes
        endcase
    end

    // Register 0 is never a real destination
    assign writeReq = writeInstr && (destAddr != '0);

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
    parameter int REG_COUNT = 32                  // 16 also works, upper address bits ignored
) (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData,
    input  logic              wbEn,               // Write strobe from writeback stage
    input  mipsPkg::regAddr_t wbAddr,
    input  mipsPkg::word_t    wbData
);

    localparam int IDX_W = $clog2(REG_COUNT);     // Used address bits

    mipsPkg::word_t   regs [REG_COUNT];           // Register storage
    logic [IDX_W-1:0] wrIdx;
    logic [IDX_W-1:0] rsIdx;
    logic [IDX_W-1:0] rtIdx;

    assign wrIdx = wbAddr[IDX_W-1:0];
    assign rsIdx = rsAddr[IDX_W-1:0];
    assign rtIdx = rtAddr[IDX_W-1:0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;                    // All registers read zero after reset
            end
        end else if (wbEn && (wrIdx != '0)) begin // Entry 0 stays zero
            regs[wrIdx] <= wbData;
        end
    end

    // Plain reads, same-cycle write bypass lives in bypassPipe
    assign rsData = regs[rsIdx];
    assign rtData = regs[rtIdx];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mipsPkg::aluCtrl_t aluCtrl,            // Operation select
    input  mipsPkg::word_t    a,                  // rs side
    input  mipsPkg::word_t    b,                  // rt or immediate side
    input  mipsPkg::shamt_t   shamt,              // Fixed shift amount
    input  logic              regWrite,           // Write request from decode
    output mipsPkg::word_t    aluResult,
    output logic              zero,               // Result is all zeros
    output logic              regWriteOut         // Write request after clear
);

    logic            regWriteClear;               // Op never writes a register
    mipsPkg::shamt_t varShamt;                    // Register-based shift amount

    assign varShamt = a[4:0];                     // Only low five bits count

    always_comb begin
        aluResult     = '0;
        regWriteClear = 1'b0;
        case (aluCtrl)
            mipsPkg::ALU_ADD:  aluResult = a + b;                 // Wraps, no trap
            mipsPkg::ALU_ADDU: aluResult = a + b;
            mipsPkg::ALU_SUB:  aluResult = a - b;                 // Wraps, no trap
            mipsPkg::ALU_SUBU: aluResult = a - b;
            mipsPkg::ALU_LUI:  aluResult = b << 16;
            mipsPkg::ALU_AND:  aluResult = a & b;
            mipsPkg::ALU_OR:   aluResult = a | b;
            mipsPkg::ALU_NOR:  aluResult = ~(a | b);
            mipsPkg::ALU_XOR:  aluResult = a ^ b;
            mipsPkg::ALU_SLL:  aluResult = b << shamt;
            mipsPkg::ALU_SLLV: aluResult = b << varShamt;
            mipsPkg::ALU_SRL:  aluResult = b >> shamt;
            mipsPkg::ALU_SRLV: aluResult = b >> varShamt;
            mipsPkg::ALU_SRA:  aluResult = $signed(b) >>> shamt;  // Sign fill
            mipsPkg::ALU_SRAV: aluResult = $signed(b) >>> varShamt;
            mipsPkg::ALU_SLT: begin
                aluResult = {31'd0, $signed(a) < $signed(b)};
            end
            mipsPkg::ALU_SLTU: begin
                aluResult = {31'd0, a < b};
            end
            mipsPkg::ALU_BEQ, mipsPkg::ALU_BNE: begin
                aluResult     = a - b;            // Zero flag reports a == b
                regWriteClear = 1'b1;
            end
            mipsPkg::ALU_JUMP: begin
                regWriteClear = 1'b1;             // Result stays 0
            end
            default: begin
                aluResult = '0;                   // Unknown code
            end
        endcase
    end

    // Branches and jumps drop the decoder's write request
    assign regWriteOut = regWriteClear ? 1'b0 : regWrite;

    assign zero = (aluResult == '0);

endmodule

// ==== src/bypassPipe.sv ====
`timescale 1ns/1ps

module bypassPipe (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instValid,       // One instruction this cycle
    input  mipsPkg::operandSrc_t srcSel,
    input  logic [15:0]          imm16,
    input  mipsPkg::shamt_t      shamt,
    input  mipsPkg::regAddr_t    rsAddr,
    input  mipsPkg::regAddr_t    rtAddr,
    input  mipsPkg::regAddr_t    destAddr,
    input  mipsPkg::word_t       rsData,          // Register file reads
    input  mipsPkg::word_t       rtData,
    input  logic                 writeReq,
    input  mipsPkg::word_t       aluResult,
    input  logic                 aluZero,
    input  logic                 aluRegWrite,
    output mipsPkg::word_t       operandA,
    output mipsPkg::word_t       operandB,
    output mipsPkg::shamt_t      aluShamt,
    output logic                 aluRegWriteReq,
    output logic                 resultValid,     // Execute stage
    output mipsPkg::word_t       result,
    output logic                 zero,
    output mipsPkg::regAddr_t    destReg,
    output logic                 regWrite,
    output logic                 wbEn,            // Writeback stage into regFile
    output mipsPkg::regAddr_t    wbAddr,
    output mipsPkg::word_t       wbData
);

    mipsPkg::word_t fwdA;                         // rs after forwarding
    mipsPkg::word_t fwdB;                         // rt after forwarding

    // Newest producer wins and register 0 never forwards
    function automatic mipsPkg::word_t pickSource(input mipsPkg::regAddr_t addr,
                                                  input mipsPkg::word_t rfData);
        mipsPkg::word_t sel;
        sel = rfData;
        if (addr != '0) begin
            if (regWrite && (destReg == addr)) sel = result;     // Execute stage
            else if (wbEn && (wbAddr == addr)) sel = wbData;     // Writeback stage
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(rsAddr, rsData);
        fwdB = pickSource(rtAddr, rtData);
    end

    assign operandA = fwdA;

    always_comb begin
        case (srcSel)
            mipsPkg::srcImmSigned: operandB = {{16{imm16[15]}}, imm16};
            mipsPkg::srcImmZero:   operandB = {16'd0, imm16};
            default:               operandB = fwdB;  // srcReg and srcShamt
        endcase
    end

    assign aluShamt       = (srcSel == mipsPkg::srcShamt) ? shamt : '0;
    assign aluRegWriteReq = writeReq && instValid;   // Idle cycles never write

    // Execute register loads at the sampling edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            regWrite    <= 1'b0;
            zero        <= 1'b0;
        end else begin
            resultValid <= instValid;
            regWrite    <= instValid && aluRegWrite;
            zero        <= instValid && aluZero;
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            result  <= aluResult;
            destReg <= destAddr;
        end
    end

    // Writeback register feeding the regFile write on the next edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= destReg;
        wbData <= result;
    end

endmodule

// ==== src/executeCore.sv ====
`timescale 1ns/1ps

module executeCore #(
    parameter int REG_COUNT = 32                  // Passed to regFile
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instValid,          // Valid strobe, no back-pressure
    input  mipsPkg::word_t    instr,
    output logic              resultValid,        // One cycle after instValid
    output mipsPkg::word_t    result,
    output logic              zero,
    output mipsPkg::regAddr_t destReg,
    output logic              regWrite
);

    mipsPkg::aluCtrl_t    aluCtrl;                // Decode outputs
    mipsPkg::operandSrc_t srcSel;
    logic [15:0]          imm16;
    mipsPkg::shamt_t      shamt;
    mipsPkg::regAddr_t    rsAddr;
    mipsPkg::regAddr_t    rtAddr;
    mipsPkg::regAddr_t    destAddr;
    logic                 writeReq;

    mipsPkg::word_t       rsData;                 // Register file reads
    mipsPkg::word_t       rtData;

    mipsPkg::word_t       operandA;               // ALU inputs
    mipsPkg::word_t       operandB;
    mipsPkg::shamt_t      aluShamt;
    logic                 aluRegWriteReq;

    mipsPkg::word_t       aluResult;              // ALU outputs
    logic                 aluZero;
    logic                 aluRegWrite;

    logic                 wbEn;                   // Writeback to register file
    mipsPkg::regAddr_t    wbAddr;
    mipsPkg::word_t       wbData;

    aluDecoder uDecoder (
        .instr(instr), .aluCtrl(aluCtrl), .srcSel(srcSel), .imm16(imm16), .shamt(shamt),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .destAddr(destAddr), .writeReq(writeReq)
    );

    regFile #(.REG_COUNT(REG_COUNT)) uRegFile (
        .clk(clk), .arstN(arstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .rsData(rsData), .rtData(rtData), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    bypassPipe uBypass (
        .clk(clk), .arstN(arstN), .instValid(instValid), .srcSel(srcSel), .imm16(imm16),
        .shamt(shamt), .rsAddr(rsAddr), .rtAddr(rtAddr), .destAddr(destAddr),
        .rsData(rsData), .rtData(rtData), .writeReq(writeReq), .aluResult(aluResult),
        .aluZero(aluZero), .aluRegWrite(aluRegWrite), .operandA(operandA),
        .operandB(operandB), .aluShamt(aluShamt), .aluRegWriteReq(aluRegWriteReq),
        .resultValid(resultValid), .result(result), .zero(zero), .destReg(destReg),
        .regWrite(regWrite), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    alu uAlu (
        .aluCtrl(aluCtrl), .a(operandA), .b(operandB), .shamt(aluShamt),
        .regWrite(aluRegWriteReq), .aluResult(aluResult), .zero(aluZero),
        .regWriteOut(aluRegWrite)
    );

endmodule

// ==== tests/executeCore_properties.sv ====
`timescale 1ns/1ps

module executeCore_properties (
    input logic              clk,
    input logic              arstN,
    input logic              instValid,
    input mipsPkg::word_t    instr,
    input logic              resultValid,
    input logic              zero,
    input mipsPkg::regAddr_t destReg,
    input logic              regWrite,
    input logic              wbEn                 // Internal writeback strobe
);

    logic [5:0] opcode;                           // Opcode of the instruction on the input
    logic       noWriteOp;                        // Branch or jump
    int         failCount = 0;                    // Failed assertion count

    assign opcode    = instr[31:26];
    assign noWriteOp = (opcode == mipsPkg::OP_BEQ) || (opcode == mipsPkg::OP_BNE) ||
                       (opcode == mipsPkg::OP_J)   || (opcode == mipsPkg::OP_JAL) ||
                       ((opcode == mipsPkg::OP_SPECIAL) && (instr[5:0] == mipsPkg::FN_JR));

    // One result per instruction with fixed one-cycle latency
    validFollows: assert property (@(posedge clk) disable iff (!arstN)
        instValid |=> resultValid)
        else begin
            failCount++;
            $error("resultValid missing one cycle after instValid");
        end

    noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
        !instValid |=> !resultValid)
        else begin
            failCount++;
            $error("resultValid raised without an instruction");
        end

    // Outputs and writeback quiet while reset is held
    quietInReset: assert property (@(posedge clk)
        !arstN |-> (!resultValid && !regWrite && !zero && !wbEn))
        else begin
            failCount++;
            $error("outputs active during reset");
        end

    noWriteToZero: assert property (@(posedge clk) disable iff (!arstN)
        regWrite |-> (destReg != '0))
        else begin
            failCount++;
            $error("regWrite set with destination register 0");
        end

    noWriteOnBranch: assert property (@(posedge clk) disable iff (!arstN)
        (instValid && noWriteOp) |=> !regWrite)
        else begin
            failCount++;
            $error("regWrite set for a branch or jump");
        end

endmodule

bind executeCore executeCore_properties uProps (
    .clk(clk), .arstN(arstN), .instValid(instValid), .instr(instr),
    .resultValid(resultValid), .zero(zero), .destReg(destReg), .regWrite(regWrite),
    .wbEn(wbEn)
);

// ==== tests/executeCoreTb.sv ====
`timescale 1ns/1ps

module executeCoreTb;

    logic              clk;
    logic              arstN;
    logic              instValid;
    mipsPkg::word_t    instr;
    logic              resultValid;
    mipsPkg::word_t    result;
    logic              zero;
    mipsPkg::regAddr_t destReg;
    logic              regWrite;

    mipsPkg::word_t modelRegs [32];               // Reference register file
    mipsPkg::word_t expResult [$];                // Expected outputs in issue order
    logic           expZero [$];
    logic [4:0]     expDest [$];
    logic           expWrite [$];
    string          expName [$];
    logic [31:0]    lfsr;
    int             mismatches;
    int             unexpected;                   // Results with nothing queued
    int             timeouts;
    int             propFails;                    // Bound checker failures
    int             waitCount;
    logic [5:0]     rFuncts [14];
    logic [5:0]     iOps [11];

    executeCore #(.REG_COUNT(32)) UUT (
        .clk(clk), .arstN(arstN), .instValid(instValid), .instr(instr),
        .resultValid(resultValid), .result(result), .zero(zero),
        .destReg(destReg), .regWrite(regWrite)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], nextBit()};
        return v;
    endfunction

    function automatic mipsPkg::word_t rType(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {mipsPkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic mipsPkg::word_t iType(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference model executing one instruction in program order
    task automatic modelExec(input mipsPkg::word_t w, input string name);
        logic [5:0]     op;
        logic [5:0]     fn;
        logic [4:0]     sh;
        logic [4:0]     dest;
        logic           wr;
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        mipsPkg::word_t se;
        mipsPkg::word_t ze;
        mipsPkg::word_t r;
        op   = w[31:26];
        fn   = w[5:0];
        sh   = w[10:6];
        a    = modelRegs[w[25:21]];
        b    = modelRegs[w[20:16]];
        se   = {{16{w[15]}}, w[15:0]};
        ze   = {16'd0, w[15:0]};
        dest = w[20:16];                          // rt for immediates
        wr   = 1'b1;
        r    = '0;
        case (op)
            mipsPkg::OP_SPECIAL: begin
                dest = w[15:11];
                case (fn)
                    mipsPkg::FN_SLL:  r = b << sh;
                    mipsPkg::FN_SRL:  r = b >> sh;
                    mipsPkg::FN_SRA:  r = $signed(b) >>> sh;
                    mipsPkg::FN_SLLV: r = b << a[4:0];
                    mipsPkg::FN_SRLV: r = b >> a[4:0];
                    mipsPkg::FN_SRAV: r = $signed(b) >>> a[4:0];
                    mipsPkg::FN_ADD, mipsPkg::FN_ADDU: r = a + b;
                    mipsPkg::FN_SUB, mipsPkg::FN_SUBU: r = a - b;
                    mipsPkg::FN_AND:  r = a & b;
                    mipsPkg::FN_OR:   r = a | b;
                    mipsPkg::FN_XOR:  r = a ^ b;
                    mipsPkg::FN_NOR:  r = ~(a | b);
                    mipsPkg::FN_SLT:  r = {31'd0, $signed(a) < $signed(b)};
                    mipsPkg::FN_SLTU: r = {31'd0, a < b};
                    default:          wr = 1'b0;  // JR
                endcase
            end
            mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU: r = a + se;
            mipsPkg::OP_SLTI:  r = {31'd0, $signed(a) < $signed(se)};
            mipsPkg::OP_SLTIU: r = {31'd0, a < se};
            mipsPkg::OP_ANDI:  r = a & ze;
            mipsPkg::OP_ORI:   r = a | ze;
            mipsPkg::OP_XORI:  r = a ^ ze;
            mipsPkg::OP_LUI:   r = {w[15:0], 16'd0};
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                r  = a - b;                       // Zero means equal
                wr = 1'b0;
            end
            default: wr = 1'b0;                   // Jumps
        endcase
        if (dest == 5'd0) wr = 1'b0;
        if (wr) modelRegs[dest] = r;
        expResult.push_back(r);
        expZero.push_back(r == '0);
        expDest.push_back(dest);
        expWrite.push_back(wr);
        expName.push_back(name);
    endtask

    task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            mismatches++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic sendInstr(input mipsPkg::word_t w, input string name);
        @(posedge clk);
        #1;
        instr     = w;
        instValid = 1'b1;
        modelExec(w, name);
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        instValid = 1'b0;
        instr     = '0;
    endtask

    task automatic loadReg(input logic [4:0] rn, input logic [31:0] v);
        sendInstr(iType(mipsPkg::OP_LUI, 5'd0, rn, v[31:16]), "load");
        sendInstr(iType(mipsPkg::OP_ORI, rn, rn, v[15:0]), "load");
    endtask

    // Compare mid-cycle while outputs are stable
    always @(negedge clk) begin
        if (arstN && resultValid) begin
            if (expResult.size() == 0) begin
                unexpected++;
                $display("Result appeared with no instruction outstanding");
            end else begin
                checkField({expName[0], " result"}, expResult[0], result);
                checkField({expName[0], " zero"}, expZero[0], zero);
                checkField({expName[0], " regWrite"}, expWrite[0], regWrite);
                if (expWrite[0]) checkField({expName[0], " destReg"}, expDest[0], destReg);
                void'(expResult.pop_front());
                void'(expZero.pop_front());
                void'(expDest.pop_front());
                void'(expWrite.pop_front());
                void'(expName.pop_front());
            end
        end
    end

    initial begin
        arstN      = 1'b1;
        instValid  = 1'b0;
        instr      = '0;
        lfsr       = 32'h832ebe3c;
        mismatches = 0;
        unexpected = 0;
        timeouts   = 0;
        propFails  = 0;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        rFuncts = '{mipsPkg::FN_SLL, mipsPkg::FN_SRL, mipsPkg::FN_SRA, mipsPkg::FN_SLLV,
                    mipsPkg::FN_SRLV, mipsPkg::FN_SRAV, mipsPkg::FN_ADD, mipsPkg::FN_ADDU,
                    mipsPkg::FN_SUB, mipsPkg::FN_SUBU, mipsPkg::FN_AND, mipsPkg::FN_OR,
                    mipsPkg::FN_XOR, mipsPkg::FN_NOR};
        iOps = '{mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU,
                 mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI,
                 mipsPkg::OP_BEQ, mipsPkg::OP_BNE, mipsPkg::OP_J};
        #1 arstN = 1'b0;                          // Reset falls after time zero
        repeat (2) @(posedge clk);
        #1 arstN = 1'b1;
        checkField("reset resultValid", 0, resultValid);
        checkField("reset regWrite", 0, regWrite);
        checkField("reset zero", 0, zero);

        // All registers read zero after reset with destination 0
        for (int i = 0; i < 32; i++) sendInstr(rType(mipsPkg::FN_OR, i, 0, 0, 0), "resetRead");
        sendInstr(iType(mipsPkg::OP_ORI, 5'd0, 5'd0, 16'h1234), "writeZero");
        sendInstr(rType(mipsPkg::FN_ADDU, 0, 0, 1, 0), "readZero");

        // Arithmetic, logic and compare
        loadReg(5'd2, 32'h8000_1234);
        loadReg(5'd3, 32'h0000_5678);
        loadReg(5'd4, 32'hffff_fff0);
        for (int i = 6; i < 14; i++) sendInstr(rType(rFuncts[i], 2, 3, 10, 0), "rArith");
        sendInstr(rType(mipsPkg::FN_SLT, 2, 3, 11, 0), "slt");
        sendInstr(rType(mipsPkg::FN_SLTU, 2, 3, 11, 0), "sltu");
        for (int i = 0; i < 7; i++) sendInstr(iType(iOps[i], 4, 12, 16'h8001), "iArith");

        // Shifts with negative register 2 for sign fill
        sendInstr(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd5, 16'd7), "shiftAmt");
        for (int i = 0; i < 3; i++) sendInstr(rType(rFuncts[i], 0, 2, 13, 5'd9), "shiftImm");
        for (int i = 3; i < 6; i++) sendInstr(rType(rFuncts[i], 5, 2, 13, 0), "shiftVar");
        idle();

        // Forwarding chains with distance 1, 2 and 3
        sendInstr(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd6, 16'd3), "fwd");
        sendInstr(rType(mipsPkg::FN_ADDU, 6, 6, 7, 0), "fwd1");
        sendInstr(rType(mipsPkg::FN_ADDU, 6, 7, 8, 0), "fwd2");
        sendInstr(rType(mipsPkg::FN_SUBU, 6, 8, 9, 0), "fwd3");
        sendInstr(rType(mipsPkg::FN_XOR, 7, 9, 7, 0), "fwdMix");
        idle();

        // Branch compare and jumps
        sendInstr(iType(mipsPkg::OP_BEQ, 5'd6, 5'd6, 16'h0010), "beqEqual");
        sendInstr(iType(mipsPkg::OP_BEQ, 5'd6, 5'd7, 16'h0010), "beqDiff");
        sendInstr(iType(mipsPkg::OP_BNE, 5'd2, 5'd3, 16'h0010), "bne");
        sendInstr({mipsPkg::OP_J, 26'h00_0abc}, "jump");
        sendInstr({mipsPkg::OP_JAL, 26'h3ff_ffff}, "jal");
        sendInstr(rType(mipsPkg::FN_JR, 6, 0, 0, 0), "jr");
        sendInstr(rType(mipsPkg::FN_OR, 6, 7, 14, 0), "afterBranch");

        // Random stream over all kept functions
        for (int n = 0; n < 200; n++) begin
            logic [4:0] pick;
            pick = randBits(5) % 27;
            if (pick < 14) begin
                sendInstr(rType(rFuncts[pick], randBits(5), randBits(5), randBits(5),
                                randBits(5)), "random");
            end else if (pick < 16) begin
                sendInstr(rType(pick == 14 ? mipsPkg::FN_SLT : mipsPkg::FN_SLTU,
                                randBits(5), randBits(5), randBits(5), 0), "random");
            end else begin
                sendInstr(iType(iOps[pick - 16], randBits(5), randBits(5), randBits(16)),
                          "random");
            end
        end
        idle();

        waitCount = 0;
        while (expResult.size() != 0 && waitCount < 20) begin
            @(posedge clk);
            waitCount++;
        end
        if (expResult.size() != 0) begin
            timeouts++;
            $display("Timed out waiting for %0d outstanding results", expResult.size());
        end
        propFails = UUT.uProps.failCount;
        $display("Errors: %0d mismatches, %0d unexpected, %0d timeouts, %0d assertion fails",
                 mismatches, unexpected, timeouts, propFails);
        if (mismatches == 0 && unexpected == 0 && timeouts == 0 && propFails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== executeCore.f ====
src/mipsPkg.sv
src/aluDecoder.sv
src/regFile.sv
src/alu.sv
src/bypassPipe.sv
src/executeCore.sv
tests/executeCore_properties.sv
tests/executeCoreTb.sv
